// File: Bender.yml
package:
  name: sparc_control_unit

sources:
  - include_dirs:
      - include
    files:
      - logic/sparc_isa_pkg.sv
      - logic/cu_ctrl_pkg.sv
      - logic/mem_op_decoder.sv
      - logic/alu_op_decoder.sv
      - logic/instr_decoder.sv
      - logic/control_stage.sv
      - logic/control_unit_top.sv
      - target: simulation
        include_dirs:
          - include
        files:
          - sim/cu_checker.sv
          - sim/tb_control_unit.sv

// File: files.f
+incdir+include
logic/sparc_isa_pkg.sv
logic/cu_ctrl_pkg.sv
logic/mem_op_decoder.sv
logic/alu_op_decoder.sv
logic/instr_decoder.sv
logic/control_stage.sv
logic/control_unit_top.sv
sim/cu_checker.sv
sim/tb_control_unit.sv

// File: include/cu_params.svh
`ifndef CU_PARAMS_SVH
`define CU_PARAMS_SVH

// instruction word width
`define CU_INSTR_W   32

// op field, picks the instruction format
`define CU_OP_MSB    31
`define CU_OP_LSB    30

// op2 field, format 00 only
`define CU_OP2_MSB   24
`define CU_OP2_LSB   22

// op3 field, formats 10 and 11
`define CU_OP3_MSB   24
`define CU_OP3_LSB   19
`define CU_OP3_W     6

// encoded alu operation
`define CU_ALU_OP_W  4

`endif

// File: logic/alu_op_decoder.sv
`default_nettype none

module alu_op_decoder
    import sparc_isa_pkg::*;
    import cu_ctrl_pkg::*;
(
    input  op3_arith_e op3,
    output logic       alu_hit,   // op3 is an alu code
    output alu_op_e    alu_op,
    output logic       cc_en      // update icc
);

    always_comb begin
        alu_hit = 1'b1;            // cleared in default below
        alu_op  = alu_add;

        case (op3)
            // arithmetic
            op3_add, op3_addcc:
                alu_op = alu_add;
            op3_addx, op3_addxcc:
                alu_op = alu_addx;
            op3_sub, op3_subcc:
                alu_op = alu_sub;
            op3_subx:
                alu_op = alu_subx;
            // logic
            op3_and, op3_andcc:
                alu_op = alu_and;
            op3_andn, op3_andncc:
                alu_op = alu_andn;
            op3_or, op3_orcc:
                alu_op = alu_or;
            op3_orn, op3_orncc:
                alu_op = alu_orn;
            op3_xor, op3_xorcc:
                alu_op = alu_xor;
            op3_xnor, op3_xnorcc:
                alu_op = alu_xnor;
            // shifts, no cc form
            op3_sll:
                alu_op = alu_sll;
            op3_srl:
                alu_op = alu_srl;
            op3_sra:
                alu_op = alu_sra;
            // jmpl, save, restore and unknown codes
            default: begin
                alu_hit = 1'b0;
                alu_op  = alu_add;
            end
        endcase
    end

    // every cc variant sits at op3[4] = 1, plain forms and shifts at 0
    assign cc_en = alu_hit & op3[4];

endmodule

`default_nettype wire

// File: logic/control_stage.sv
`default_nettype none

module control_stage
    import cu_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  logic      squash,       // sampled together with instr_valid
    input  logic      dec_jmpl,
    input  logic      dec_call,
    input  logic      dec_branch,
    input  logic      dec_load,
    input  logic      dec_rf_en,
    input  logic      dec_mem_se,
    input  logic      dec_mem_rw,
    input  logic      dec_mem_en,
    input  mem_size_e dec_mem_size,
    input  alu_op_e   dec_alu_op,
    input  logic      dec_cc_en,
    output logic      ctrl_valid,
    output logic      jmpl,
    output logic      call,
    output logic      branch,
    output logic      load,
    output logic      rf_en,
    output logic      mem_se,
    output logic      mem_rw,
    output logic      mem_en,
    output mem_size_e mem_size,
    output alu_op_e   alu_op,
    output logic      cc_en
);

    logic take;    // accept this cycle's decode

    assign take = instr_valid & ~squash;

    always_ff @(posedge clk) begin
        if (!rst_n || !take) begin
            // bubble, every control line low
            ctrl_valid <= 1'b0;
            jmpl       <= 1'b0;
            call       <= 1'b0;
            branch     <= 1'b0;
            load       <= 1'b0;
            rf_en      <= 1'b0;
            mem_se     <= 1'b0;
            mem_rw     <= 1'b0;
            mem_en     <= 1'b0;
            mem_size   <= size_byte;
            alu_op     <= alu_add;
            cc_en      <= 1'b0;
        end else begin
            ctrl_valid <= 1'b1;
            jmpl       <= dec_jmpl;
            call       <= dec_call;
            branch     <= dec_branch;
            load       <= dec_load;
            rf_en      <= dec_rf_en;
            mem_se     <= dec_mem_se;
            mem_rw     <= dec_mem_rw;
            mem_en     <= dec_mem_en;
            mem_size   <= dec_mem_size;
            alu_op     <= dec_alu_op;
            cc_en      <= dec_cc_en;
        end
    end

endmodule

`default_nettype wire

// File: logic/control_unit_top.sv
`default_nettype none

`include "cu_params.svh"

module control_unit_top
    import cu_ctrl_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,   // one cycle per instruction
    input  logic [`CU_INSTR_W-1:0] instr,
    input  logic                   squash,
    output logic                   ctrl_valid,
    output logic                   jmpl,
    output logic                   call,
    output logic                   branch,
    output logic                   load,
    output logic                   rf_en,
    output logic                   mem_se,
    output logic                   mem_rw,
    output logic                   mem_en,
    output mem_size_e              mem_size,
    output alu_op_e                alu_op,
    output logic                   cc_en
);

    // combinational decode, into the stage register
    logic      dec_jmpl;
    logic      dec_call;
    logic      dec_branch;
    logic      dec_load;
    logic      dec_rf_en;
    logic      dec_mem_se;
    logic      dec_mem_rw;
    logic      dec_mem_en;
    mem_size_e dec_mem_size;
    alu_op_e   dec_alu_op;
    logic      dec_cc_en;

    instr_decoder dec_i (
        .instr        (instr),
        .dec_jmpl     (dec_jmpl),
        .dec_call     (dec_call),
        .dec_branch   (dec_branch),
        .dec_load     (dec_load),
        .dec_rf_en    (dec_rf_en),
        .dec_mem_se   (dec_mem_se),
        .dec_mem_rw   (dec_mem_rw),
        .dec_mem_en   (dec_mem_en),
        .dec_mem_size (dec_mem_size),
        .dec_alu_op   (dec_alu_op),
        .dec_cc_en    (dec_cc_en)
    );

    control_stage stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .squash       (squash),
        .dec_jmpl     (dec_jmpl),
        .dec_call     (dec_call),
        .dec_branch   (dec_branch),
        .dec_load     (dec_load),
        .dec_rf_en    (dec_rf_en),
        .dec_mem_se   (dec_mem_se),
        .dec_mem_rw   (dec_mem_rw),
        .dec_mem_en   (dec_mem_en),
        .dec_mem_size (dec_mem_size),
        .dec_alu_op   (dec_alu_op),
        .dec_cc_en    (dec_cc_en),
        .ctrl_valid   (ctrl_valid),
        .jmpl         (jmpl),
        .call         (call),
        .branch       (branch),
        .load         (load),
        .rf_en        (rf_en),
        .mem_se       (mem_se),
        .mem_rw       (mem_rw),
        .mem_en       (mem_en),
        .mem_size     (mem_size),
        .alu_op       (alu_op),
        .cc_en        (cc_en)
    );

endmodule

`default_nettype wire

// File: logic/cu_ctrl_pkg.sv
`default_nettype none

`include "cu_params.svh"

package cu_ctrl_pkg;

    // operation code seen by the execute stage alu
    typedef enum logic [`CU_ALU_OP_W-1:0] {
        alu_add    = 4'd0,
        alu_addx   = 4'd1,    // with carry
        alu_sub    = 4'd2,
        alu_subx   = 4'd3,    // with borrow
        alu_and    = 4'd4,
        alu_or     = 4'd5,
        alu_xor    = 4'd6,
        alu_xnor   = 4'd7,
        alu_andn   = 4'd8,
        alu_orn    = 4'd9,
        alu_sll    = 4'd10,
        alu_srl    = 4'd11,
        alu_sra    = 4'd12,
        alu_pass_b = 4'd14    // sethi, operand b straight through
    } alu_op_e;

    // data memory access width
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

endpackage

`default_nettype wire

// File: logic/instr_decoder.sv
`default_nettype none

`include "cu_params.svh"

module instr_decoder
    import sparc_isa_pkg::*;
    import cu_ctrl_pkg::*;
(
    input  logic [`CU_INSTR_W-1:0] instr,
    output logic                   dec_jmpl,
    output logic                   dec_call,
    output logic                   dec_branch,
    output logic                   dec_load,
    output logic                   dec_rf_en,
    output logic                   dec_mem_se,
    output logic                   dec_mem_rw,
    output logic                   dec_mem_en,
    output mem_size_e              dec_mem_size,
    output alu_op_e                dec_alu_op,
    output logic                   dec_cc_en
);

    op_fmt_e               fmt;
    op2_e                  op2;
    logic [`CU_OP3_W-1:0]  op3;      // shared by both sub-decoders
    op3_arith_e            op3_arith;

    // memory sub-decoder results
    logic      mem_hit;
    logic      mem_is_load;
    logic      mem_sign_ext;
    logic      mem_rw;
    mem_size_e mem_size;

    // alu sub-decoder results
    logic      alu_hit;
    alu_op_e   alu_op;
    logic      alu_cc_en;

    assign fmt       = op_fmt_e'(instr[`CU_OP_MSB:`CU_OP_LSB]);
    assign op2       = op2_e'(instr[`CU_OP2_MSB:`CU_OP2_LSB]);
    assign op3       = instr[`CU_OP3_MSB:`CU_OP3_LSB];
    assign op3_arith = op3_arith_e'(op3);

    mem_op_decoder mem_dec_i (
        .op3      (op3_mem_e'(op3)),
        .mem_hit  (mem_hit),
        .is_load  (mem_is_load),
        .sign_ext (mem_sign_ext),
        .mem_rw   (mem_rw),
        .mem_size (mem_size)
    );

    alu_op_decoder alu_dec_i (
        .op3     (op3_arith),
        .alu_hit (alu_hit),
        .alu_op  (alu_op),
        .cc_en   (alu_cc_en)
    );

    always_comb begin
        // all zero unless a rule below fires
        dec_jmpl     = 1'b0;
        dec_call     = 1'b0;
        dec_branch   = 1'b0;
        dec_load     = 1'b0;
        dec_rf_en    = 1'b0;
        dec_mem_se   = 1'b0;
        dec_mem_rw   = 1'b0;
        dec_mem_en   = 1'b0;
        dec_mem_size = size_byte;
        dec_alu_op   = alu_add;
        dec_cc_en    = 1'b0;

        case (fmt)
            fmt_branch_sethi: begin
                if (op2 == op2_sethi)
                    dec_alu_op = alu_pass_b;   // imm22 handled by operand b path
                else if (op2 == op2_branch)
                    dec_branch = 1'b1;
            end
            fmt_call: begin
                dec_call  = 1'b1;
                dec_rf_en = 1'b1;               // return address into r15
            end
            fmt_mem: begin
                if (mem_hit) begin
                    dec_load     = mem_is_load;
                    dec_rf_en    = mem_is_load; // stores leave the register file alone
                    dec_mem_en   = 1'b1;
                    dec_mem_rw   = mem_rw;
                    dec_mem_se   = mem_sign_ext;
                    dec_mem_size = mem_size;
                end
            end
            fmt_arith: begin
                case (op3_arith)
                    op3_jmpl:
                        dec_jmpl = 1'b1;
                    // window spill/fill goes through memory
                    op3_save, op3_restore: begin
                        dec_rf_en    = 1'b1;
                        dec_mem_en   = 1'b1;
                        dec_mem_size = size_word;
                    end
                    default: begin
                        if (alu_hit) begin
                            dec_alu_op = alu_op;
                            dec_rf_en  = 1'b1;
                            dec_cc_en  = alu_cc_en;
                        end
                    end
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/mem_op_decoder.sv
`default_nettype none

module mem_op_decoder
    import sparc_isa_pkg::*;
    import cu_ctrl_pkg::*;
(
    input  op3_mem_e  op3,
    output logic      mem_hit,    // op3 is one of the load/store codes
    output logic      is_load,    // 0 means store
    output logic      sign_ext,
    output logic      mem_rw,     // 1 write
    output mem_size_e mem_size
);

    always_comb begin
        // unknown op3 -> nothing set
        mem_hit  = 1'b0;
        is_load  = 1'b0;
        sign_ext = 1'b0;
        mem_rw   = 1'b0;
        mem_size = size_byte;

        case (op3)
            op3_ld: begin
                mem_hit  = 1'b1;
                is_load  = 1'b1;
                mem_size = size_word;
            end
            op3_ldub: begin
                mem_hit  = 1'b1;
                is_load  = 1'b1;
                mem_size = size_byte;
            end
            op3_lduh: begin
                mem_hit  = 1'b1;
                is_load  = 1'b1;
                mem_size = size_half;
            end
            op3_ldsb: begin
                mem_hit  = 1'b1;
                is_load  = 1'b1;
                sign_ext = 1'b1;     // signed byte
                mem_size = size_byte;
            end
            op3_ldsh: begin
                mem_hit  = 1'b1;
                is_load  = 1'b1;
                sign_ext = 1'b1;     // signed half
                mem_size = size_half;
            end
            // stores never sign extend
            op3_stb: begin
                mem_hit  = 1'b1;
                mem_rw   = 1'b1;
                mem_size = size_byte;
            end
            op3_sth: begin
                mem_hit  = 1'b1;
                mem_rw   = 1'b1;
                mem_size = size_half;
            end
            op3_st: begin
                mem_hit  = 1'b1;
                mem_rw   = 1'b1;
                mem_size = size_word;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/sparc_isa_pkg.sv
`default_nettype none

`include "cu_params.svh"

package sparc_isa_pkg;

    // instr[31:30]
    typedef enum logic [1:0] {
        fmt_branch_sethi = 2'b00,
        fmt_call         = 2'b01,
        fmt_arith        = 2'b10,
        fmt_mem          = 2'b11
    } op_fmt_e;

    // instr[24:22], only two codes matter here
    typedef enum logic [2:0] {
        op2_branch = 3'b010,
        op2_sethi  = 3'b100
    } op2_e;

    // load / store op3 under format 11
    typedef enum logic [`CU_OP3_W-1:0] {
        op3_ld   = 6'b000000,   // word
        op3_ldub = 6'b000001,
        op3_lduh = 6'b000010,
        op3_st   = 6'b000100,
        op3_stb  = 6'b000101,
        op3_sth  = 6'b000110,
        op3_ldsb = 6'b001001,   // signed byte
        op3_ldsh = 6'b001010    // signed half
    } op3_mem_e;

    // op3 under format 10; bit 4 marks the cc variants
    typedef enum logic [`CU_OP3_W-1:0] {
        op3_add     = 6'b000000,
        op3_and     = 6'b000001,
        op3_or      = 6'b000010,
        op3_xor     = 6'b000011,
        op3_sub     = 6'b000100,
        op3_andn    = 6'b000101,
        op3_orn     = 6'b000110,
        op3_xnor    = 6'b000111,
        op3_addx    = 6'b001000,
        op3_subx    = 6'b001100,
        op3_addcc   = 6'b010000,
        op3_andcc   = 6'b010001,
        op3_orcc    = 6'b010010,
        op3_xorcc   = 6'b010011,
        op3_subcc   = 6'b010100,
        op3_andncc  = 6'b010101,
        op3_orncc   = 6'b010110,
        op3_xnorcc  = 6'b010111,
        op3_addxcc  = 6'b011000,
        op3_sll     = 6'b100101,
        op3_srl     = 6'b100110,
        op3_sra     = 6'b100111,
        op3_jmpl    = 6'b111000,
        op3_save    = 6'b111100,
        op3_restore = 6'b111101
    } op3_arith_e;

endpackage

`default_nettype wire

// File: sim/cu_checker.sv
`default_nettype none

`include "cu_params.svh"

module cu_checker
    import cu_ctrl_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   line_applied,   // current inputs are the next file line
    input  logic                   instr_valid,
    input  logic                   squash,
    input  logic [`CU_INSTR_W-1:0] instr,
    input  logic                   ctrl_valid,
    input  logic                   jmpl,
    input  logic                   call,
    input  logic                   branch,
    input  logic                   load,
    input  logic                   rf_en,
    input  logic                   mem_se,
    input  logic                   mem_rw,
    input  logic                   mem_en,
    input  mem_size_e              mem_size,
    input  alu_op_e                alu_op,
    input  logic                   cc_en,
    output int                     error_count,
    output int                     lines_checked
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam STIM_FILE = "sim/cu_stimulus.txt";
    localparam int COLS     = 15;
    localparam int MAX_ROWS = 256;
    localparam int NFIELDS  = 12;    // expected columns after instr

    logic [31:0] stim_mem [0:COLS*MAX_ROWS-1];
    logic [31:0] exp_q    [0:NFIELDS-1];   // what the outputs must show now
    int          row_count;
    int          next_row;
    int          pend_line;    // -1 on idle or reset cycles
    int          load_errors;
    int          cmp_errors;

    assign error_count = load_errors + cmp_errors;

    initial begin
        int fd;
        load_errors   = 0;
        cmp_errors    = 0;
        lines_checked = 0;
        next_row      = 0;
        pend_line     = -1;
        row_count     = 0;
        for (int k = 0; k < NFIELDS; k++)
            exp_q[k] = '0;     // reset state
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("checker: cannot open stimulus file %s", STIM_FILE);
            load_errors = 1;
        end else begin
            $fclose(fd);
            for (int a = 0; a < COLS * MAX_ROWS; a++)
                stim_mem[a] = 32'hdead0000 | a;
            $readmemh(STIM_FILE, stim_mem);
            while (row_count < MAX_ROWS && stim_mem[row_count * COLS] <= 32'd1)
                row_count++;
        end
    end

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            cmp_errors++;
            if (pend_line >= 0)
                $display("mismatch %s: expected 0x%0h, actual 0x%0h, line %0d",
                         name, expected, actual, pend_line);
            else
                $display("mismatch %s: expected 0x%0h, actual 0x%0h, idle cycle at %0t",
                         name, expected, actual, $time);
        end
    endtask

    task automatic clear_expect();
        for (int k = 0; k < NFIELDS; k++)
            exp_q[k] = '0;
        pend_line = -1;
    endtask

    task automatic take_row();
        int base;
        if (next_row >= row_count) begin
            $display("error: a line was applied past the end of the stimulus file");
            cmp_errors++;
            clear_expect();
        end else begin
            base = next_row * COLS;
            if (instr_valid !== stim_mem[base][0] || squash !== stim_mem[base + 1][0] ||
                instr !== stim_mem[base + 2]) begin
                $display("error: applied inputs differ from stimulus line %0d", next_row);
                cmp_errors++;
            end
            for (int k = 0; k < NFIELDS; k++)
                exp_q[k] = stim_mem[base + 3 + k];
            pend_line = next_row;
            next_row++;
        end
    endtask

    // negedge, away from the edge where inputs and outputs change
    always @(negedge clk) begin
        check_field("ctrl_valid", exp_q[0], ctrl_valid);
        check_field("jmpl", exp_q[1], jmpl);
        check_field("call", exp_q[2], call);
        check_field("branch", exp_q[3], branch);
        check_field("load", exp_q[4], load);
        check_field("rf_en", exp_q[5], rf_en);
        check_field("mem_se", exp_q[6], mem_se);
        check_field("mem_rw", exp_q[7], mem_rw);
        check_field("mem_en", exp_q[8], mem_en);
        check_field("mem_size", exp_q[9], mem_size);
        check_field("alu_op", exp_q[10], alu_op);
        check_field("cc_en", exp_q[11], cc_en);
        if (pend_line >= 0)
            lines_checked++;
        // expectation for the next rising edge
        if (rst_n && line_applied)
            take_row();
        else
            clear_expect();        // reset or idle gives a bubble
    end

endmodule

`default_nettype wire

// File: sim/cu_stimulus.txt
// valid squash instr ctrl_valid jmpl call branch load rf_en mem_se mem_rw mem_en mem_size alu_op cc_en
// all hex, an idle line (valid 0) may be followed by random extra idle cycles
1 0 C2008000 1 0 0 0 1 1 0 0 1 2 0 0 // ld
1 0 C2088000 1 0 0 0 1 1 0 0 1 0 0 0 // ldub
1 0 C2108000 1 0 0 0 1 1 0 0 1 1 0 0 // lduh
1 0 C2488000 1 0 0 0 1 1 1 0 1 0 0 0 // ldsb
1 0 C2508000 1 0 0 0 1 1 1 0 1 1 0 0 // ldsh
1 0 C2208000 1 0 0 0 0 0 0 1 1 2 0 0 // st
1 0 C2288000 1 0 0 0 0 0 0 1 1 0 0 0 // stb
1 0 C2308000 1 0 0 0 0 0 0 1 1 1 0 0 // sth
0 0 00000000 0 0 0 0 0 0 0 0 0 0 0 0
1 0 82008003 1 0 0 0 0 1 0 0 0 0 0 0 // add
1 0 82088003 1 0 0 0 0 1 0 0 0 0 4 0 // and
1 0 82108003 1 0 0 0 0 1 0 0 0 0 5 0 // or
1 0 82188003 1 0 0 0 0 1 0 0 0 0 6 0 // xor
1 0 82208003 1 0 0 0 0 1 0 0 0 0 2 0 // sub
1 0 82288003 1 0 0 0 0 1 0 0 0 0 8 0 // andn
1 0 82308003 1 0 0 0 0 1 0 0 0 0 9 0 // orn
1 0 82388003 1 0 0 0 0 1 0 0 0 0 7 0 // xnor
1 0 82408003 1 0 0 0 0 1 0 0 0 0 1 0 // addx
1 0 82608003 1 0 0 0 0 1 0 0 0 0 3 0 // subx
1 0 82808003 1 0 0 0 0 1 0 0 0 0 0 1 // addcc
1 0 82888003 1 0 0 0 0 1 0 0 0 0 4 1
1 0 82908003 1 0 0 0 0 1 0 0 0 0 5 1
1 0 82988003 1 0 0 0 0 1 0 0 0 0 6 1
1 0 82A08003 1 0 0 0 0 1 0 0 0 0 2 1 // subcc
1 0 82A88003 1 0 0 0 0 1 0 0 0 0 8 1
1 0 82B08003 1 0 0 0 0 1 0 0 0 0 9 1
1 0 82B88003 1 0 0 0 0 1 0 0 0 0 7 1 // xnorcc
1 0 82C08003 1 0 0 0 0 1 0 0 0 0 1 1 // addxcc
1 0 83288003 1 0 0 0 0 1 0 0 0 0 A 0 // sll
1 0 83308003 1 0 0 0 0 1 0 0 0 0 B 0 // srl
1 0 83388003 1 0 0 0 0 1 0 0 0 0 C 0 // sra
0 1 40000010 0 0 0 0 0 0 0 0 0 0 0 0 // squash without valid
1 0 03012345 1 0 0 0 0 0 0 0 0 0 E 0 // sethi
1 0 10800010 1 0 0 1 0 0 0 0 0 0 0 0 // ba
1 0 40000010 1 0 1 0 0 1 0 0 0 0 0 0 // call
1 0 83C08003 1 1 0 0 0 0 0 0 0 0 0 0 // jmpl
1 0 83E08003 1 0 0 0 0 1 0 0 1 2 0 0 // save
1 0 83E88003 1 0 0 0 0 1 0 0 1 2 0 0 // restore
1 0 00000000 1 0 0 0 0 0 0 0 0 0 0 0 // zero word
1 0 82488003 1 0 0 0 0 0 0 0 0 0 0 0 // op3 09 unlisted
1 0 82E08003 1 0 0 0 0 0 0 0 0 0 0 0 // subxcc unlisted
1 0 C2188000 1 0 0 0 0 0 0 0 0 0 0 0 // ldd unlisted
1 0 00000123 1 0 0 0 0 0 0 0 0 0 0 0 // op2 000
1 0 01800004 1 0 0 0 0 0 0 0 0 0 0 0 // op2 110
0 0 C2008000 0 0 0 0 0 0 0 0 0 0 0 0
1 1 C2008000 0 0 0 0 0 0 0 0 0 0 0 0 // squashed ld
1 1 82808003 0 0 0 0 0 0 0 0 0 0 0 0 // squashed addcc
1 0 C2008000 1 0 0 0 1 1 0 0 1 2 0 0 // mixed burst from here
1 0 82808003 1 0 0 0 0 1 0 0 0 0 0 1
1 0 40000010 1 0 1 0 0 1 0 0 0 0 0 0
1 1 82208003 0 0 0 0 0 0 0 0 0 0 0 0
1 0 C2208000 1 0 0 0 0 0 0 1 1 2 0 0
1 0 03012345 1 0 0 0 0 0 0 0 0 0 E 0
1 0 83388003 1 0 0 0 0 1 0 0 0 0 C 0
1 0 10800010 1 0 0 1 0 0 0 0 0 0 0 0
1 0 83E08003 1 0 0 0 0 1 0 0 1 2 0 0
0 0 83C08003 0 0 0 0 0 0 0 0 0 0 0 0

// File: sim/tb_control_unit.sv
`default_nettype none

`include "cu_params.svh"

module tb_control_unit
    import cu_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam STIM_FILE = "sim/cu_stimulus.txt";
    localparam int COLS     = 15;     // hex tokens per stimulus line
    localparam int MAX_ROWS = 256;

    logic                   clk;
    logic                   rst_n;
    logic                   instr_valid;
    logic                   squash;
    logic [`CU_INSTR_W-1:0] instr;
    logic                   line_applied;   // inputs carry a file line this cycle

    logic      ctrl_valid;
    logic      jmpl;
    logic      call;
    logic      branch;
    logic      load;
    logic      rf_en;
    logic      mem_se;
    logic      mem_rw;
    logic      mem_en;
    mem_size_e mem_size;
    alu_op_e   alu_op;
    logic      cc_en;

    logic [31:0] stim_mem [0:COLS*MAX_ROWS-1];
    int          gap_len  [0:MAX_ROWS-1];   // extra idle cycles after each line
    int          row_count;
    int          total_gaps;
    int          cycle_count;
    int          cycle_limit;
    int          tb_errors;
    int          chk_errors;
    int          lines_checked;

    control_unit_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .squash      (squash),
        .ctrl_valid  (ctrl_valid),
        .jmpl        (jmpl),
        .call        (call),
        .branch      (branch),
        .load        (load),
        .rf_en       (rf_en),
        .mem_se      (mem_se),
        .mem_rw      (mem_rw),
        .mem_en      (mem_en),
        .mem_size    (mem_size),
        .alu_op      (alu_op),
        .cc_en       (cc_en)
    );

    cu_checker chk_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .line_applied  (line_applied),
        .instr_valid   (instr_valid),
        .squash        (squash),
        .instr         (instr),
        .ctrl_valid    (ctrl_valid),
        .jmpl          (jmpl),
        .call          (call),
        .branch        (branch),
        .load          (load),
        .rf_en         (rf_en),
        .mem_se        (mem_se),
        .mem_rw        (mem_rw),
        .mem_en        (mem_en),
        .mem_size      (mem_size),
        .alu_op        (alu_op),
        .cc_en         (cc_en),
        .error_count   (chk_errors),
        .lines_checked (lines_checked)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    // run length guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("%0d of %0d lines checked, %0d errors", lines_checked, row_count,
                     tb_errors + chk_errors + 1);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic load_stimulus();
        // address dependent fill, never a legal valid token
        for (int a = 0; a < COLS * MAX_ROWS; a++)
            stim_mem[a] = 32'hdead0000 | a;
        $readmemh(STIM_FILE, stim_mem);
        row_count = 0;
        while (row_count < MAX_ROWS && stim_mem[row_count * COLS] <= 32'd1)
            row_count++;
    endtask

    task automatic plan_gaps();
        total_gaps = 0;
        for (int r = 0; r < row_count; r++) begin
            // only idle lines stretch, bursts stay back to back
            if (stim_mem[r * COLS] == 32'd0)
                gap_len[r] = $urandom % 4;
            else
                gap_len[r] = 0;
            total_gaps += gap_len[r];
        end
    endtask

    task automatic drive_idle();
        instr_valid  <= 1'b0;
        squash       <= 1'b0;
        line_applied <= 1'b0;
    endtask

    task automatic apply_row(input int r);
        @(posedge clk);
        instr_valid  <= stim_mem[r * COLS][0];
        squash       <= stim_mem[r * COLS + 1][0];
        instr        <= stim_mem[r * COLS + 2];
        line_applied <= 1'b1;
        repeat (gap_len[r]) begin
            @(posedge clk);
            drive_idle();
        end
    endtask

    initial begin
        int fd;
        rst_n        = 1'b0;
        instr_valid  = 1'b1;             // call strobe held through reset
        squash       = 1'b0;
        instr        = 32'h40000010;     // must not reach the outputs
        line_applied = 1'b0;
        tb_errors    = 0;
        row_count    = 0;
        total_gaps   = 0;
        cycle_count  = 0;
        cycle_limit  = 50;
        void'($urandom(32'hd297));       // single seed for the run

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("error: cannot open stimulus file %s", STIM_FILE);
            tb_errors++;
        end else begin
            $fclose(fd);
            load_stimulus();
            plan_gaps();
            cycle_limit = 2 * row_count + 50 + total_gaps;
            repeat (8) @(posedge clk);   // reset held 8 cycles
            rst_n <= 1'b1;
            drive_idle();                // strobe drops with reset release
            if (row_count == 0) begin
                $display("error: stimulus file %s holds no lines", STIM_FILE);
                tb_errors++;
            end else begin
                for (int r = 0; r < row_count; r++)
                    apply_row(r);
                @(posedge clk);
                drive_idle();
                while (lines_checked < row_count)
                    @(posedge clk);
                repeat (3) @(posedge clk);   // trailing idle cycles checked too
            end
        end

        $display("%0d of %0d lines checked, %0d errors", lines_checked, row_count,
                 tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
